// ==== dv/step_motor_ctrl_tb.sv ====
`timescale 1ns/1ps
`include "step_motor_macros.svh"

module step_motor_ctrl_tb;
	import ramp_table_pkg::*;
	import step_axis_pkg::*;

	localparam int NBR = `STEP_MOTOR_NBR;
	localparam int DIV = `STEP_TICK_DIV;
	localparam int TBL_N = 16;
	localparam int WAIT_LIMIT = 50000; // cycles per wait

	logic clk = 1'b0;
	logic resetn;
	logic i_tbl_init;
	logic i_tbl_wr;
	ramp_speed_t i_tbl_data;
	logic [NBR-1:0] i_start;
	logic [NBR-1:0] i_stop;
	logic [NBR-1:0] i_dir;
	logic [NBR-1:0] i_zpd;
	step_count_t [NBR-1:0] i_steps;
	ramp_speed_t [NBR-1:0] i_speed;
	step_ms_t [NBR-1:0] i_ms;
	step_count_t [NBR-1:0] i_stroke;
	logic [NBR-1:0] o_drive;
	logic [NBR-1:0] o_dir;
	step_ms_t [NBR-1:0] o_ms;
	logic [NBR-1:0] o_busy;
	logic [NBR-1:0] o_zpsign;
	logic [NBR-1:0] o_tpsign;
	ramp_speed_t ramp [TBL_N]; // loaded table, slowest first
	logic [31:0] rng;

	step_motor_ctrl dut (.*);

	always #20 clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// a gap must be DIV times the requested speed or a table entry, never faster
	function automatic logic legal_gap(input int unsigned gap, input ramp_speed_t speed);
		int unsigned p;
		logic hit;
		p = gap / DIV;
		hit = (p == speed);
		for (int i = 0; i < TBL_N; i++) begin
			if (ramp[i] == p) begin
				hit = 1'b1;
			end
		end
		return (gap % DIV == 0) && (p >= speed) && hit;
	endfunction

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic value_error(input string test, input longint expected, input longint actual);
		stop_run($sformatf("[ERROR] %s: expected %0d, actual %0d", test, expected, actual));
	endtask

	task automatic setup_axis(input int k, input logic dir, input int steps, input int speed,
		input int ms);
		i_dir[k] = dir;
		i_steps[k] = step_count_t'(steps);
		i_speed[k] = ramp_speed_t'(speed);
		i_ms[k] = step_ms_t'(ms);
	endtask

	task automatic pulse_ctrl(input logic [NBR-1:0] start_mask, input logic [NBR-1:0] stop_mask);
		i_start = start_mask;
		i_stop = stop_mask;
		@(posedge clk);
		#2;
		i_start = '0;
		i_stop = '0;
	endtask

	task automatic wait_pulses(input int k, input int n);
		int seen;
		int cycles;
		seen = 0;
		cycles = 0;
		while (seen < n && cycles < WAIT_LIMIT) begin
			@(posedge clk);
			#2;
			cycles++;
			if (o_drive[k]) begin
				seen++;
			end
		end
		if (seen < n) begin
			stop_run($sformatf("axis %0d gave %0d of %0d step pulses before the timeout",
				k, seen, n));
		end
	endtask

	task automatic wait_idle(input int k);
		int cycles;
		cycles = 0;
		while (o_busy[k] && cycles < WAIT_LIMIT) begin
			@(posedge clk);
			#2;
			cycles++;
		end
		if (o_busy[k]) begin
			stop_run($sformatf("axis %0d still busy after %0d cycles", k, WAIT_LIMIT));
		end
	endtask

	task automatic load_ramp();
		ramp_speed_t t;
		for (int i = 0; i < TBL_N; i++) begin
			rng = xorshift32(rng);
			ramp[i] = ramp_speed_t'(3 + rng % 40);
		end
		for (int i = 0; i < TBL_N; i++) begin
			for (int j = 0; j < TBL_N - 1 - i; j++) begin
				if (ramp[j] < ramp[j+1]) begin
					t = ramp[j];
					ramp[j] = ramp[j+1];
					ramp[j+1] = t;
				end
			end
		end
		i_tbl_init = 1'b1;
		for (int i = 0; i < TBL_N; i++) begin
			i_tbl_wr = 1'b1;
			i_tbl_data = ramp[i];
			@(posedge clk);
			#2;
		end
		i_tbl_wr = 1'b0;
		i_tbl_init = 1'b0;
	endtask

	for (genvar k = 0; k < NBR; k++) begin : g_check
		step_count_t pulses;
		step_count_t pos;
		step_count_t pos_now;
		step_count_t exp_steps;
		ramp_speed_t exp_speed;
		step_ms_t    exp_ms;
		logic        exp_dir;
		logic        first;
		logic        stopped;
		logic        zero_stop;
		logic        gap_new;
		int unsigned since;
		int unsigned gap;
		int unsigned last_gap;

		// position already holds the step while its pulse is high
		assign pos_now = !o_drive[k] ? pos : (o_dir[k] ? pos + 1'b1 : pos - 1'b1);

		always @(posedge clk) begin
			if (!resetn) begin
				pulses <= '0;
				pos <= '0;
				exp_dir <= 1'b0;
				exp_ms <= '0;
				first <= 1'b1;
				stopped <= 1'b0;
				zero_stop <= 1'b0;
				gap_new <= 1'b0;
				since <= 0;
			end else begin
				gap_new <= 1'b0;
				since <= since + 1;
				if (i_start[k] && !o_busy[k]) begin // a start while busy is dropped
					exp_dir <= i_dir[k];
					exp_ms <= i_ms[k];
					exp_steps <= i_steps[k];
					exp_speed <= i_speed[k];
					pulses <= '0;
					first <= 1'b1;
					stopped <= 1'b0;
					zero_stop <= 1'b0;
				end
				if (i_stop[k] && o_busy[k]) begin
					stopped <= 1'b1;
				end
				if (o_busy[k] && !o_dir[k] && i_zpd[k]) begin
					pos <= '0;
					zero_stop <= 1'b1;
				end else if (o_drive[k]) begin
					pos <= pos_now;
				end
				if (o_drive[k]) begin
					pulses <= pulses + 1'b1;
					since <= 1;
					first <= 1'b0;
					if (!first) begin
						last_gap <= gap;
						gap <= since;
						gap_new <= 1'b1;
					end
				end
			end
		end

		idle_quiet: assert property (@(posedge clk) disable iff (!resetn)
			!o_busy[k] |-> !o_drive[k])
			else value_error($sformatf("idle_quiet axis %0d", k), 0, $sampled(o_drive[k]));

		step_count: assert property (@(posedge clk) disable iff (!resetn)
			($fell(o_busy[k]) && !stopped && !zero_stop) |-> (pulses == exp_steps))
			else value_error($sformatf("step_count axis %0d", k), $sampled(exp_steps),
				$sampled(pulses));

		stop_short: assert property (@(posedge clk) disable iff (!resetn)
			($fell(o_busy[k]) && stopped) |-> (pulses < exp_steps))
			else stop_run($sformatf("axis %0d ran all its steps despite the stop", k));

		gap_legal: assert property (@(posedge clk) disable iff (!resetn)
			gap_new |-> legal_gap(gap, exp_speed))
			else stop_run($sformatf("axis %0d step gap of %0d cycles is not a legal period",
				k, $sampled(gap)));

		gap_after_stop: assert property (@(posedge clk) disable iff (!resetn)
			(gap_new && stopped) |-> (gap >= last_gap))
			else stop_run($sformatf("axis %0d sped up during the stop ramp", k));

		dir_held: assert property (@(posedge clk) disable iff (!resetn)
			o_busy[k] |-> (o_dir[k] == exp_dir))
			else value_error($sformatf("dir_held axis %0d", k), $sampled(exp_dir),
				$sampled(o_dir[k]));

		ms_held: assert property (@(posedge clk) disable iff (!resetn)
			o_busy[k] |-> (o_ms[k] == exp_ms))
			else value_error($sformatf("ms_held axis %0d", k), $sampled(exp_ms),
				$sampled(o_ms[k]));

		tpsign_match: assert property (@(posedge clk) disable iff (!resetn)
			o_tpsign[k] == (pos_now == i_stroke[k]))
			else value_error($sformatf("tpsign_match axis %0d", k),
				$sampled(pos_now == i_stroke[k]), $sampled(o_tpsign[k]));

		zero_halt: assert property (@(posedge clk) disable iff (!resetn)
			(o_busy[k] && !o_dir[k] && i_zpd[k]) |=> (!o_busy[k] && !o_drive[k] && o_zpsign[k]))
			else stop_run($sformatf("axis %0d did not halt on the zero sensor", k));
	end

	reset_quiet: assert property (@(posedge clk)
		$rose(resetn) |-> ((o_drive | o_busy | o_zpsign) == '0))
		else value_error("reset_quiet", 0, $sampled(o_drive | o_busy | o_zpsign));

	initial begin
		rng = 32'he59e;
		resetn = 1'b0;
		i_tbl_init = 1'b0;
		i_tbl_wr = 1'b0;
		i_tbl_data = '0;
		i_start = '0;
		i_stop = '0;
		i_zpd = '0;
		for (int k = 0; k < NBR; k++) begin
			setup_axis(k, 1'b0, 1, 1, 0);
			i_stroke[k] = (k == 0) ? 16'd30 : 16'd5;
		end
		repeat (16) @(posedge clk);
		#2;
		resetn = 1'b1;
		load_ramp();
		// both axes at once, axis 1 shorter than twice its ramp
		setup_axis(0, 1'b1, 40, 5, 3);
		setup_axis(1, 1'b1, 10, 8, 5);
		pulse_ctrl(2'b11, 2'b00);
		wait_pulses(0, 3);
		setup_axis(0, 1'b0, 7, 2, 6);
		pulse_ctrl(2'b01, 2'b00);
		wait_idle(0);
		wait_idle(1);
		// early stop well into cruise
		setup_axis(0, 1'b1, 200, 5, 1);
		pulse_ctrl(2'b01, 2'b00);
		wait_pulses(0, 24);
		pulse_ctrl(2'b00, 2'b01);
		wait_idle(0);
		// zero sensor on axis 1 while axis 0 runs
		setup_axis(0, 1'b1, 30, 6, 4);
		setup_axis(1, 1'b0, 300, 8, 2);
		pulse_ctrl(2'b11, 2'b00);
		wait_pulses(1, 12);
		i_zpd[1] = 1'b1;
		wait_idle(1);
		i_zpd[1] = 1'b0;
		wait_idle(0);
		repeat (4 * DIV) @(posedge clk);
		$display("Done: no errors");
		$finish;
	end

endmodule

// ==== include/step_motor_macros.svh ====
`ifndef STEP_MOTOR_MACROS_SVH
`define STEP_MOTOR_MACROS_SVH

// step period in ticks
`define STEP_SPEED_W 16

// ramp table address
`define STEP_ADDR_W 6

// step counts, position and stroke
`define STEP_COUNT_W 16

`define STEP_MS_W 3
`define STEP_MOTOR_NBR 2

// tick ring length, >= 4 and >= STEP_MOTOR_NBR (table read takes two cycles)
`define STEP_TICK_DIV 8

`endif

// ==== rtl/ramp_table_pkg.sv ====
`include "step_motor_macros.svh"

package ramp_table_pkg;

	// one table entry, step period in ticks
	typedef logic [`STEP_SPEED_W-1:0] ramp_speed_t;

	typedef logic [`STEP_ADDR_W-1:0] ramp_addr_t;

	// full address space of the table
	localparam int unsigned RAMP_DEPTH = 1 << `STEP_ADDR_W;

endpackage

// ==== rtl/ramp_table_ram.sv ====
`timescale 1ns/1ps

module ramp_table_ram (
	input  logic                        clk,
	input  logic                        i_we,
	input  ramp_table_pkg::ramp_addr_t  i_addr_a,
	input  ramp_table_pkg::ramp_speed_t i_data_a,
	output ramp_table_pkg::ramp_speed_t o_q_a,
	input  ramp_table_pkg::ramp_addr_t  i_addr_b,
	output ramp_table_pkg::ramp_speed_t o_q_b
);
	import ramp_table_pkg::*;

	ramp_speed_t mem [RAMP_DEPTH];

	// port a, write wins, read returns old data
	always_ff @(posedge clk) begin
		if (i_we) begin
			mem[i_addr_a] <= i_data_a;
		end
		o_q_a <= mem[i_addr_a];
	end

	// port b read only
	always_ff @(posedge clk) begin
		o_q_b <= mem[i_addr_b];
	end

endmodule

// ==== rtl/step_axis.sv ====
`timescale 1ns/1ps
`include "step_motor_macros.svh"

module step_axis (
	input  logic                        clk,
	input  logic                        resetn,
	input  logic                        i_tick,
	input  ramp_table_pkg::ramp_addr_t  i_tbl_last,
	output logic                        o_acc_en,
	output ramp_table_pkg::ramp_addr_t  o_acc_addr,
	input  ramp_table_pkg::ramp_speed_t i_acc_data,
	output logic                        o_dec_en,
	output ramp_table_pkg::ramp_addr_t  o_dec_addr,
	input  ramp_table_pkg::ramp_speed_t i_dec_data,
	input  logic                        i_start,
	input  logic                        i_stop,
	input  logic                        i_dir,
	input  step_axis_pkg::step_count_t  i_steps,
	input  ramp_table_pkg::ramp_speed_t i_speed,
	input  step_axis_pkg::step_ms_t     i_ms,
	input  step_axis_pkg::step_count_t  i_stroke,
	input  logic                        i_zpd,
	output logic                        o_drive,
	output logic                        o_dir,
	output step_axis_pkg::step_ms_t     o_ms,
	output logic                        o_busy,
	output logic                        o_zpsign,
	output logic                        o_tpsign,
	output step_axis_pkg::axis_state_e  o_state
);
	import ramp_table_pkg::*;
	import step_axis_pkg::*;

	axis_state_e state;
	ramp_addr_t  idx;        // next accel entry
	ramp_speed_t speed;      // cruise period
	ramp_speed_t period;     // period of the running interval
	ramp_speed_t elapsed;    // ticks since last step
	step_count_t steps_left; // pulses still to emit
	step_count_t ramp_n;     // table intervals taken on the way up
	step_count_t left_n;
	step_count_t dec_n;
	step_count_t position;
	logic        done;       // busy drops the cycle after the last pulse
	logic        fire;
	logic        going_dec;
	logic        last_step;
	logic        zero_hit;
	logic [1:0]  acc_pipe;   // table data lands two cycles after the read
	logic [1:0]  dec_pipe;

	assign left_n    = steps_left - 1'b1;
	assign going_dec = (state == AXIS_DECEL) || (left_n <= ramp_n);
	assign dec_n     = (left_n < ramp_n) ? left_n : ramp_n;
	assign last_step = going_dec && (dec_n == '0);
	assign zero_hit  = o_busy && !o_dir && i_zpd;

	// period 0 after start makes the first tick step
	assign fire = i_tick && o_busy && !done && !zero_hit &&
		(({1'b0, elapsed} + 17'd1) >= {1'b0, period});

	// the read issued on a step sets the period of the next interval
	assign o_acc_en   = fire && !going_dec && (state == AXIS_ACCEL);
	assign o_acc_addr = idx;
	assign o_dec_en   = fire && going_dec && !last_step;
	assign o_dec_addr = ramp_addr_t'(dec_n - 1'b1); // mirror of the way up

	assign o_busy   = (state != AXIS_IDLE);
	assign o_state  = state;
	assign o_tpsign = (position == i_stroke);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state    <= AXIS_IDLE;
			done     <= 1'b0;
			o_drive  <= 1'b0;
			o_dir    <= 1'b0;
			o_ms     <= '0;
			o_zpsign <= 1'b0;
			position <= '0;
			acc_pipe <= '0;
			dec_pipe <= '0;
		end else begin
			o_drive  <= fire;
			acc_pipe <= {acc_pipe[0], o_acc_en};
			dec_pipe <= {dec_pipe[0], o_dec_en};
			if (state == AXIS_IDLE) begin
				if (i_start && (i_steps != '0)) begin
					state    <= AXIS_ACCEL;
					o_dir    <= i_dir;
					o_ms     <= i_ms;
					o_zpsign <= 1'b0;
				end
			end else if (zero_hit) begin
				state    <= AXIS_IDLE;
				done     <= 1'b0;
				position <= '0;
				o_zpsign <= 1'b1;
			end else if (done) begin
				state <= AXIS_IDLE;
				done  <= 1'b0;
			end else begin
				if (fire) begin
					position <= o_dir ? position + 1'b1 : position - 1'b1;
					if (last_step) begin
						done <= 1'b1;
					end else if (going_dec) begin
						state <= AXIS_DECEL;
					end
				end
				// top of the ramp reached
				if (acc_pipe[1] && (state == AXIS_ACCEL) &&
					((i_acc_data <= speed) || (idx == i_tbl_last))) begin
					state <= AXIS_CRUISE;
				end
				if (i_stop && ((state == AXIS_ACCEL) || (state == AXIS_CRUISE))) begin
					state <= AXIS_DECEL;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == AXIS_IDLE) begin
			if (i_start) begin
				speed      <= i_speed;
				steps_left <= i_steps;
				period     <= '0;
				elapsed    <= '0;
				idx        <= '0;
				ramp_n     <= '0;
			end
		end else begin
			if (fire) begin
				elapsed    <= '0;
				steps_left <= going_dec ? dec_n : left_n;
				if ((state == AXIS_CRUISE) && !going_dec) begin
					period <= speed;
				end
			end else if (i_tick) begin
				elapsed <= elapsed + 1'b1;
			end
			if (acc_pipe[1]) begin
				if (i_acc_data > speed) begin
					period <= i_acc_data;
					ramp_n <= ramp_n + 1'b1;
					if (idx != i_tbl_last) begin
						idx <= idx + 1'b1;
					end
				end else begin
					period <= speed; // never faster than requested
				end
			end
			if (dec_pipe[1]) begin
				period <= i_dec_data;
			end
		end
	end

	drive_in_move: assert property (@(posedge clk) disable iff (!resetn)
		o_drive |-> o_busy);

	one_step_per_tick: assert property (@(posedge clk) disable iff (!resetn)
		o_drive |=> !o_drive [*(`STEP_TICK_DIV - 1)]);

	// ramp data must be in place before the next tick
	data_before_tick: assert property (@(posedge clk) disable iff (!resetn)
		(acc_pipe[1] || dec_pipe[1]) |-> !i_tick);

endmodule

// ==== rtl/step_axis_pkg.sv ====
`include "step_motor_macros.svh"

package step_axis_pkg;

	// step count, position and stroke
	typedef logic [`STEP_COUNT_W-1:0] step_count_t;

	typedef logic [`STEP_MS_W-1:0] step_ms_t;

	typedef enum logic [1:0] {
		AXIS_IDLE   = 2'd0,
		AXIS_ACCEL  = 2'd1, // walking up the ramp
		AXIS_CRUISE = 2'd2,
		AXIS_DECEL  = 2'd3  // walking back down
	} axis_state_e;

endpackage

// ==== rtl/step_motor_ctrl.sv ====
`timescale 1ns/1ps
`include "step_motor_macros.svh"

module step_motor_ctrl (
	input  logic                                                clk,
	input  logic                                                resetn,
	input  logic                                                i_tbl_init,
	input  logic                                                i_tbl_wr,
	input  ramp_table_pkg::ramp_speed_t                         i_tbl_data,
	input  logic [`STEP_MOTOR_NBR-1:0]                          i_start,
	input  logic [`STEP_MOTOR_NBR-1:0]                          i_stop,
	input  logic [`STEP_MOTOR_NBR-1:0]                          i_dir,
	input  step_axis_pkg::step_count_t [`STEP_MOTOR_NBR-1:0]    i_steps,
	input  ramp_table_pkg::ramp_speed_t [`STEP_MOTOR_NBR-1:0]   i_speed,
	input  step_axis_pkg::step_ms_t [`STEP_MOTOR_NBR-1:0]       i_ms,
	input  step_axis_pkg::step_count_t [`STEP_MOTOR_NBR-1:0]    i_stroke,
	input  logic [`STEP_MOTOR_NBR-1:0]                          i_zpd,
	output logic [`STEP_MOTOR_NBR-1:0]                          o_drive,
	output logic [`STEP_MOTOR_NBR-1:0]                          o_dir,
	output step_axis_pkg::step_ms_t [`STEP_MOTOR_NBR-1:0]       o_ms,
	output logic [`STEP_MOTOR_NBR-1:0]                          o_busy,
	output logic [`STEP_MOTOR_NBR-1:0]                          o_zpsign,
	output logic [`STEP_MOTOR_NBR-1:0]                          o_tpsign
);
	import ramp_table_pkg::*;
	import step_axis_pkg::*;

	localparam int NBR = `STEP_MOTOR_NBR;

	ramp_addr_t  wr_addr;
	ramp_addr_t  tbl_last;  // highest loaded entry
	logic        tbl_we;
	logic [`STEP_TICK_DIV-1:0] tick_ring;
	logic [NBR-1:0] acc_en;
	logic [NBR-1:0] dec_en;
	logic [NBR-1:0] axis_idle;
	ramp_addr_t  acc_addr [NBR];
	ramp_addr_t  dec_addr [NBR];
	ramp_addr_t  acc_merge;
	ramp_addr_t  dec_merge;
	ramp_addr_t  acc_addr_q;
	ramp_addr_t  dec_addr_q;
	ramp_speed_t acc_q;
	ramp_speed_t dec_q;
	axis_state_e axis_state [NBR];

	assign tbl_we = i_tbl_init && i_tbl_wr;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			wr_addr  <= '0;
			tbl_last <= '0;
		end else if (!i_tbl_init) begin
			wr_addr <= '0;
		end else if (i_tbl_wr) begin
			wr_addr  <= wr_addr + 1'b1;
			tbl_last <= wr_addr;
		end
	end

	// one-hot, one axis ticked per cycle
	always_ff @(posedge clk) begin
		if (!resetn) begin
			tick_ring <= {{(`STEP_TICK_DIV-1){1'b0}}, 1'b1};
		end else begin
			tick_ring <= {tick_ring[`STEP_TICK_DIV-2:0], tick_ring[`STEP_TICK_DIV-1]};
		end
	end

	// idle axes hold their enables low, so an OR picks the ticked one
	always_comb begin
		acc_merge = '0;
		dec_merge = '0;
		for (int k = 0; k < NBR; k++) begin
			acc_merge |= acc_addr[k] & {`STEP_ADDR_W{acc_en[k]}};
			dec_merge |= dec_addr[k] & {`STEP_ADDR_W{dec_en[k]}};
		end
	end

	always_ff @(posedge clk) begin
		acc_addr_q <= acc_merge;
		dec_addr_q <= dec_merge;
	end

	ramp_table_ram u_ramp_table (
		.clk      (clk),
		.i_we     (tbl_we),
		.i_addr_a (tbl_we ? wr_addr : acc_addr_q),
		.i_data_a (i_tbl_data),
		.o_q_a    (acc_q),
		.i_addr_b (dec_addr_q),
		.o_q_b    (dec_q)
	);

	for (genvar k = 0; k < NBR; k++) begin : g_axis
		step_axis u_axis (
			.clk        (clk),
			.resetn     (resetn),
			.i_tick     (tick_ring[k]),
			.i_tbl_last (tbl_last),
			.o_acc_en   (acc_en[k]),
			.o_acc_addr (acc_addr[k]),
			.i_acc_data (acc_q),
			.o_dec_en   (dec_en[k]),
			.o_dec_addr (dec_addr[k]),
			.i_dec_data (dec_q),
			.i_start    (i_start[k]),
			.i_stop     (i_stop[k]),
			.i_dir      (i_dir[k]),
			.i_steps    (i_steps[k]),
			.i_speed    (i_speed[k]),
			.i_ms       (i_ms[k]),
			.i_stroke   (i_stroke[k]),
			.i_zpd      (i_zpd[k]),
			.o_drive    (o_drive[k]),
			.o_dir      (o_dir[k]),
			.o_ms       (o_ms[k]),
			.o_busy     (o_busy[k]),
			.o_zpsign   (o_zpsign[k]),
			.o_tpsign   (o_tpsign[k]),
			.o_state    (axis_state[k])
		);

		assign axis_idle[k] = (axis_state[k] == AXIS_IDLE);
	end

	single_reader: assert property (@(posedge clk) disable iff (!resetn)
		$onehot0(acc_en | dec_en));

	// loading under a running axis would corrupt its ramp
	load_while_idle: assert property (@(posedge clk) disable iff (!resetn)
		tbl_we |-> &axis_idle);

endmodule

// ==== step_motor_ctrl.f ====
+incdir+include
rtl/ramp_table_pkg.sv
rtl/step_axis_pkg.sv
rtl/ramp_table_ram.sv
rtl/step_axis.sv
rtl/step_motor_ctrl.sv
dv/step_motor_ctrl_tb.sv
